// ==== dv/op_patterns.txt ====
# columns: op a b expected, all in hex
# op 0 is mulu, 1 is mulh, 2 is divu, 3 is divs
0 00000003 00000005 0000000f
0 80000000 00000002 00000000
0 ffffffff ffffffff 00000001
0 12345678 00000010 23456780
0 0000ffff 00010001 ffffffff
0 deadbeef 00000001 deadbeef
0 00000007 00000006 0000002a
0 ffffffff 00000002 fffffffe
1 ffffffff ffffffff fffffffe
1 80000000 00000002 00000001
1 12345678 00000010 00000001
1 00010000 00010000 00000001
1 00000003 00000005 00000000
1 c0000000 c0000000 90000000
1 ffffffff 00000002 00000001
2 00000064 00000007 0000000e
2 00000005 00000009 00000000
2 ffffffff 00000001 ffffffff
2 ffffffff 00000010 0fffffff
2 80000000 00000003 2aaaaaaa
2 12345678 12345678 00000001
2 000003e8 0000000a 00000064
2 00000000 00000005 00000000
3 00000064 00000007 0000000e
3 ffffff9c 00000007 fffffff2
3 00000064 fffffff9 fffffff2
3 ffffff9c fffffff9 0000000e
3 80000000 ffffffff 80000000
3 80000000 00000002 c0000000
3 fffffff9 00000002 fffffffd
3 00000007 fffffffe fffffffd
3 fffffc18 0000000a ffffff9c

// ==== tb.f ====
src/arith_pkg.sv
src/arith_fifo.sv
src/iter_multiplier.sv
src/iter_divider.sv
src/op_sequencer.sv
src/arith_engine.sv
dv/result_checker.sv
dv/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module tb_top -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && ! grep -q "Errors found" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== dv/tb_top.sv ====
module tb_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD     = 20;
    localparam int          HOLD_AT        = 12; // command index that starts the read stall
    localparam int          HOLD_LEN       = 60;
    localparam int          WD_PER_PATTERN = 60;
    localparam int          WD_MARGIN      = 200;
    localparam logic [31:0] LFSR_SEED      = 32'h3314;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic                         clk;
    logic                         rst;
    logic                         cmd_valid;
    logic                         cmd_full;
    logic                         res_read;
    logic                         res_avail;
    logic                         end_check;
    logic                         hold_req;
    logic                         saw_full;
    logic                         loaded;
    arith_pkg::arith_cmd_t        cmd;
    arith_pkg::arith_res_t        res;
    logic [arith_pkg::DATA_W-1:0] exp_value;
    logic [31:0]                  lfsr_state;
    arith_pkg::arith_cmd_t        cmd_list[$];
    logic [arith_pkg::DATA_W-1:0] exp_list[$];
    int                           chk_errors;
    int                           results_seen;
    int                           tb_errors;

    arith_engine u_dut (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_full  (cmd_full),
        .res_read  (res_read),
        .res       (res),
        .res_avail (res_avail)
    );

    result_checker u_chk (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_full     (cmd_full),
        .exp_value    (exp_value),
        .res_read     (res_read),
        .res          (res),
        .res_avail    (res_avail),
        .end_check    (end_check),
        .error_count  (chk_errors),
        .results_seen (results_seen)
    );

    // galois form, the bit shifted out is the one taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : main_proc
        int                           fd;
        string                        line;
        logic [31:0]                  op_word;
        logic [arith_pkg::DATA_W-1:0] a_word;
        logic [arith_pkg::DATA_W-1:0] b_word;
        logic [arith_pkg::DATA_W-1:0] e_word;
        arith_pkg::arith_cmd_t        c;
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        exp_value  = '0;
        res_read   = 1'b0;
        end_check  = 1'b0;
        hold_req   = 1'b0;
        saw_full   = 1'b0;
        loaded     = 1'b0;
        tb_errors  = 0;
        lfsr_state = LFSR_SEED;
        fd = $fopen("dv/op_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file dv/op_patterns.txt");
            $display("Errors found");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 4 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %h %h %h", op_word, a_word, b_word, e_word) == 4) begin
                        c.op = arith_pkg::arith_op_e'(op_word[1:0]);
                        c.a  = a_word;
                        c.b  = b_word;
                        cmd_list.push_back(c);
                        exp_list.push_back(e_word);
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            repeat (10) @(posedge clk); // idle stretch, nothing may come out here
            for (int i = 0; i < cmd_list.size(); i++) begin
                cmd_valid <= 1'b1;
                cmd       <= cmd_list[i];
                exp_value <= exp_list[i];
                if (i == HOLD_AT) begin
                    hold_req <= 1'b1;
                end
                @(posedge clk);
                while (cmd_full) @(posedge clk); // re-present until the FIFO takes it
            end
            cmd_valid <= 1'b0;
            while (results_seen < cmd_list.size()) @(posedge clk);
            end_check <= 1'b1;
            repeat (2) @(posedge clk);
            if (!saw_full) begin
                $display("cmd_full never rose while reads were stalled");
                tb_errors++;
            end
            $display("closing: %0d checker errors, %0d testbench errors",
                     chk_errors, tb_errors);
            if (chk_errors == 0 && tb_errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    initial begin : read_proc
        int hold_cycles;
        hold_cycles = 0;
        forever begin
            @(posedge clk);
            if (hold_req && hold_cycles < HOLD_LEN) begin
                hold_cycles++;
                if (cmd_full) begin
                    saw_full = 1'b1;
                end
                res_read <= 1'b0;
            end else begin
                res_read   <= lfsr_state[0];
                lfsr_state = lfsr_step(lfsr_state);
            end
        end
    end

    initial begin : watchdog_proc
        wait (loaded);
        repeat (cmd_list.size() * WD_PER_PATTERN + WD_MARGIN) @(posedge clk);
        $display("timeout, the results did not all come out in time");
        $display("Errors found");
        $finish;
    end

endmodule

// ==== dv/result_checker.sv ====
module result_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_valid,
    input  arith_pkg::arith_cmd_t        cmd,
    input  logic                         cmd_full,
    input  logic [arith_pkg::DATA_W-1:0] exp_value,
    input  logic                         res_read,
    input  arith_pkg::arith_res_t        res,
    input  logic                         res_avail,
    input  logic                         end_check,
    output int                           error_count,
    output int                           results_seen
);

    timeunit 1ns;
    timeprecision 1ps;

    arith_pkg::arith_res_t exp_q[$]; // expected results in acceptance order
    int                    accepted;
    logic                  end_done;

    initial begin
        error_count  = 0;
        results_seen = 0;
        accepted     = 0;
        end_done     = 1'b0;
    end

    always @(posedge clk) begin : compare_proc
        arith_pkg::arith_res_t exp_r;
        if (!rst) begin
            if (cmd_valid && !cmd_full) begin
                exp_r.op    = cmd.op;
                exp_r.value = exp_value;
                exp_q.push_back(exp_r);
                accepted++;
            end
            if (res_read && res_avail) begin
                results_seen++;
                if (exp_q.size() == 0) begin
                    $display("a result was read out while no result was expected");
                    error_count++;
                end else begin
                    exp_r = exp_q.pop_front();
                    if (res !== exp_r) begin
                        $display("[ERROR] %0t: op %s expected %s %h got %s %h", $time,
                                 exp_r.op.name(), exp_r.op.name(), exp_r.value,
                                 res.op.name(), res.value);
                        error_count++;
                    end
                end
            end
            // nothing may show up at the ports before the first command
            if (accepted == 0 && (res_avail || cmd_full)) begin
                $display("[ERROR] %0t: res_avail or cmd_full high before any command", $time);
                error_count++;
            end
            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("%0d accepted commands never produced a result", exp_q.size());
                    error_count++;
                end
            end
        end
    end

endmodule

// ==== src/arith_engine.sv ====
module arith_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  arith_pkg::arith_cmd_t cmd,
    output logic                  cmd_full,
    input  logic                  res_read,
    output arith_pkg::arith_res_t res,
    output logic                  res_avail
);

    localparam int W = arith_pkg::DATA_W;

    arith_pkg::arith_cmd_t cmd_head;
    arith_pkg::arith_res_t res_data;
    logic                  cmd_avail;
    logic                  cmd_pop;
    logic                  res_push;
    logic                  res_full;
    logic                  mul_start;
    logic                  mul_ready;
    logic [2*W-1:0]        mul_product;
    logic                  div_start;
    logic                  div_signed;
    logic                  div_ready;
    logic [W-1:0]          div_quotient;
    logic [W-1:0]          op_a;
    logic [W-1:0]          op_b;

    // strobes against a full FIFO are dropped inside the FIFO itself
    arith_fifo #(
        .WIDTH  ($bits(arith_pkg::arith_cmd_t)),
        .ADDR_W (arith_pkg::CMD_FIFO_AW)
    ) u_cmd_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr    (cmd_valid),
        .din   (cmd),
        .rd    (cmd_pop),
        .dout  (cmd_head),
        .avail (cmd_avail),
        .full  (cmd_full)
    );

    arith_fifo #(
        .WIDTH  ($bits(arith_pkg::arith_res_t)),
        .ADDR_W (arith_pkg::RES_FIFO_AW)
    ) u_res_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr    (res_push),
        .din   (res_data),
        .rd    (res_read),
        .dout  (res),
        .avail (res_avail),
        .full  (res_full)
    );

    op_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .cmd_avail    (cmd_avail),
        .cmd_head     (cmd_head),
        .cmd_pop      (cmd_pop),
        .mul_start    (mul_start),
        .mul_ready    (mul_ready),
        .mul_product  (mul_product),
        .div_start    (div_start),
        .div_signed   (div_signed),
        .div_ready    (div_ready),
        .div_quotient (div_quotient),
        .res_full     (res_full),
        .res_push     (res_push),
        .res_data     (res_data),
        .op_a         (op_a),
        .op_b         (op_b)
    );

    iter_multiplier u_mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .a       (op_a),
        .b       (op_b),
        .product (mul_product),
        .ready   (mul_ready)
    );

    iter_divider u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .signed_op (div_signed),
        .a         (op_a),
        .b         (op_b),
        .quotient  (div_quotient),
        .ready     (div_ready)
    );

endmodule

// ==== src/op_sequencer.sv ====
module op_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_avail,
    input  arith_pkg::arith_cmd_t          cmd_head,
    output logic                           cmd_pop,
    output logic                           mul_start,
    input  logic                           mul_ready,
    input  logic [2*arith_pkg::DATA_W-1:0] mul_product,
    output logic                           div_start,
    output logic                           div_signed,
    input  logic                           div_ready,
    input  logic [arith_pkg::DATA_W-1:0]   div_quotient,
    input  logic                           res_full,
    output logic                           res_push,
    output arith_pkg::arith_res_t          res_data,
    output logic [arith_pkg::DATA_W-1:0]   op_a,
    output logic [arith_pkg::DATA_W-1:0]   op_b
);

    localparam int W = arith_pkg::DATA_W;

    arith_pkg::seq_state_e state;
    arith_pkg::arith_cmd_t cmd_q;
    logic                  is_mul;
    logic                  unit_ready;

    assign is_mul     = (cmd_q.op == arith_pkg::OP_MULU) || (cmd_q.op == arith_pkg::OP_MULH);
    assign unit_ready = is_mul ? mul_ready : div_ready;

    assign cmd_pop    = (state == arith_pkg::SEQ_IDLE) && cmd_avail;
    assign mul_start  = (state == arith_pkg::SEQ_START) && is_mul;
    assign div_start  = (state == arith_pkg::SEQ_START) && !is_mul;
    assign div_signed = cmd_q.op == arith_pkg::OP_DIVS;
    assign res_push   = (state == arith_pkg::SEQ_PUSH) && !res_full;
    assign op_a       = cmd_q.a;
    assign op_b       = cmd_q.b;

    // units hold their outputs until the next start, so no result register is needed
    always_comb begin
        res_data.op = cmd_q.op;
        case (cmd_q.op)
            arith_pkg::OP_MULU: res_data.value = mul_product[W-1:0];
            arith_pkg::OP_MULH: res_data.value = mul_product[2*W-1:W];
            default:            res_data.value = div_quotient;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            cmd_q <= cmd_head; // head is valid on the same edge that pops it
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arith_pkg::SEQ_IDLE;
        end else begin
            case (state)
                arith_pkg::SEQ_IDLE: begin
                    if (cmd_avail) begin
                        state <= arith_pkg::SEQ_START;
                    end
                end
                arith_pkg::SEQ_START: begin
                    state <= arith_pkg::SEQ_BUSY;
                end
                arith_pkg::SEQ_BUSY: begin
                    if (unit_ready) begin
                        state <= arith_pkg::SEQ_PUSH;
                    end
                end
                arith_pkg::SEQ_PUSH: begin
                    if (!res_full) begin
                        state <= arith_pkg::SEQ_IDLE;
                    end
                end
                default: state <= arith_pkg::SEQ_IDLE;
            endcase
        end
    end

    // the chosen unit has to drop ready right after its start, or BUSY would fall through
    a_ready_drops: assert property (@(posedge clk) disable iff (rst)
        (state == arith_pkg::SEQ_START) |=> !unit_ready)
        else $error("unit kept ready high after start");

    a_push_ready: assert property (@(posedge clk) disable iff (rst) res_push |-> unit_ready)
        else $error("result pushed while its unit was not ready");

endmodule

// ==== src/iter_divider.sv ====
module iter_divider (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         signed_op,
    input  logic [arith_pkg::DATA_W-1:0] a,
    input  logic [arith_pkg::DATA_W-1:0] b,
    output logic [arith_pkg::DATA_W-1:0] quotient,
    output logic                         ready
);

    localparam int W     = arith_pkg::DATA_W;
    localparam int CNT_W = $clog2(W + 1);

    logic [W-1:0]     rem;
    logic [W-1:0]     quo;
    logic [W-1:0]     divisor;
    logic [W:0]       trial;
    logic [W-1:0]     a_mag;
    logic [W-1:0]     b_mag;
    logic             neg;
    logic [CNT_W-1:0] count;

    // magnitudes for the signed case, the most negative value maps onto itself
    assign a_mag = (signed_op && a[W-1]) ? -a : a;
    assign b_mag = (signed_op && b[W-1]) ? -b : b;

    // shift the next dividend bit into the remainder and try the subtraction
    assign trial = {rem, quo[W-1]} - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            neg   <= 1'b0;
        end else if (start) begin
            count <= CNT_W'(W);
            neg   <= signed_op && (a[W-1] ^ b[W-1]);
        end else if (!ready) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem     <= '0;
            quo     <= a_mag;
            divisor <= b_mag;
        end else if (!ready) begin
            if (trial[W]) begin
                rem <= {rem[W-2:0], quo[W-1]}; // borrow, so the remainder is restored
                quo <= {quo[W-2:0], 1'b0};
            end else begin
                rem <= trial[W-1:0];
                quo <= {quo[W-2:0], 1'b1};
            end
        end
    end

    // a zero divisor never borrows and leaves an all-ones quotient
    assign ready    = count == '0;
    assign quotient = neg ? -quo : quo;

    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> ready)
        else $error("divider started while busy");

endmodule

// ==== src/iter_multiplier.sv ====
module iter_multiplier (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic [arith_pkg::DATA_W-1:0]   a,
    input  logic [arith_pkg::DATA_W-1:0]   b,
    output logic [2*arith_pkg::DATA_W-1:0] product,
    output logic                           ready
);

    localparam int W     = arith_pkg::DATA_W;
    localparam int STEP  = arith_pkg::MUL_STEP_BITS;
    localparam int CNT_W = $clog2(arith_pkg::MUL_STEPS + 1);

    logic [W-1:0]     a_q;
    logic [W-1:0]     b_q;
    logic [2*W-1:0]   acc;
    logic [2*W-1:0]   partial;
    logic [STEP-1:0]  a_top;
    logic [CNT_W-1:0] steps;

    // the most significant chunk of a goes first, so the accumulator shifts up
    assign a_top   = a_q[W-1 -: STEP];
    assign partial = (2*W)'(b_q) * (2*W)'(a_top);

    always_ff @(posedge clk) begin
        if (rst) begin
            steps <= '0;
        end else if (start) begin
            steps <= CNT_W'(arith_pkg::MUL_STEPS);
        end else if (!ready) begin
            steps <= steps - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            b_q <= b;
            acc <= '0;
        end else if (!ready) begin
            acc <= (acc << STEP) + partial;
            a_q <= a_q << STEP;
        end
    end

    assign ready   = steps == '0;
    assign product = acc;

    // the sequencer must not restart a multiply that is still running
    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> ready)
        else $error("multiplier started while busy");

endmodule

// ==== src/arith_fifo.sv ====
module arith_fifo #(
    parameter int WIDTH  = 8,
    parameter int ADDR_W = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr,
    input  logic [WIDTH-1:0] din,
    input  logic             rd,
    output logic [WIDTH-1:0] dout,
    output logic             avail,
    output logic             full
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W:0]   count;
    logic              do_rd;
    logic              do_wr;

    assign full  = count[ADDR_W]; // only set when count equals the depth
    assign avail = count != '0;
    assign do_rd = rd && avail;
    assign do_wr = wr && !full;
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_rd, do_wr})
                2'b01:   count <= count + 1'b1;
                2'b10:   count <= count - 1'b1;
                default: count <= count; // read and write together keep the level
            endcase
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
        else $error("fifo count above depth");

    a_count_floor: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |=> (count <= 1))
        else $error("fifo count wrapped below zero");

endmodule

// ==== src/arith_pkg.sv ====
package arith_pkg;

    // operand and result width
    localparam int DATA_W = 32;

    // the multiplier consumes this many bits of a per busy cycle
    localparam int MUL_STEP_BITS = 8;
    localparam int MUL_STEPS = DATA_W / MUL_STEP_BITS;

    // both FIFOs hold four entries
    localparam int CMD_FIFO_AW = 2;
    localparam int RES_FIFO_AW = 2;

    typedef enum logic [1:0] {
        OP_MULU = 2'd0, // low word of the unsigned product
        OP_MULH = 2'd1, // high word of the unsigned product
        OP_DIVU = 2'd2, // unsigned quotient
        OP_DIVS = 2'd3  // signed quotient, truncated toward zero
    } arith_op_e;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_START = 2'd1,
        SEQ_BUSY  = 2'd2,
        SEQ_PUSH  = 2'd3
    } seq_state_e;

    // one host command as it sits in the command FIFO
    typedef struct packed {
        arith_op_e         op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } arith_cmd_t;

    // one result, tagged with the opcode that produced it
    typedef struct packed {
        arith_op_e         op;
        logic [DATA_W-1:0] value;
    } arith_res_t;

endpackage
